//--- runSim.sh
#!/bin/sh
# Build the fpAddSub testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f vlog.f --top-module fpAddSubTb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1

//--- sim/fpAddRefModel.svh
`ifndef FP_ADD_REF_MODEL_SVH
`define FP_ADD_REF_MODEL_SVH

// Expected result of a +/- b, exact integer arithmetic on a wide field
function automatic resultT refAddSub(input fpWordT a, input fpWordT b, input logic sub);
	resultT r;
	logic sa;
	logic sb;					// Sign of b after the operation
	logic nanA;
	logic nanB;
	logic infA;
	logic infB;
	logic bigB;
	logic sgn;
	logic lost;
	int ea;
	int eb;
	int eL;
	int d;
	int p;
	int e;
	logic [63:0] mA;
	logic [63:0] mB;
	logic [63:0] xL;
	logic [63:0] xS;
	logic [63:0] sum;
	logic [63:0] q;
	logic [63:0] rem;
	logic [63:0] half;

	r = '0;
	sa = a[31];
	sb = b[31] ^ sub;
	ea = int'(a[30:23]);
	eb = int'(b[30:23]);
	nanA = (ea == `FP_EXP_MAX) && (a[22:0] != '0);
	nanB = (eb == `FP_EXP_MAX) && (b[22:0] != '0);
	infA = (ea == `FP_EXP_MAX) && (a[22:0] == '0);
	infB = (eb == `FP_EXP_MAX) && (b[22:0] == '0);
	if (nanA || nanB || (infA && infB && (sa != sb))) begin
		r.p = `FP_QNAN;
		r.flags.invalid = 1'b1;
		return r;
	end
	if (infA || infB) begin
		r.p = {infA ? sa : sb, 8'hFF, 23'd0};		// Infinity passes through
		r.flags.overflow = 1'b1;
		r.flags.inexact = 1'b1;
		return r;
	end
	mA = (ea == 0) ? 64'd0 : {40'd0, 1'b1, a[22:0]};	// Subnormal reads as zero
	mB = (eb == 0) ? 64'd0 : {40'd0, 1'b1, b[22:0]};
	bigB = (eb > ea) || ((eb == ea) && (mB > mA));
	eL = bigB ? eb : ea;
	d = bigB ? (eb - ea) : (ea - eb);
	xL = (bigB ? mB : mA) << 32;		// 32 spare bits below the LSB
	xS = bigB ? (mA << 32) : (mB << 32);
	// Far below the round bit only nonzero matters
	xS = (d <= 32) ? (xS >> d) : {63'd0, xS != 64'd0};
	sum = (sa != sb) ? (xL - xS) : (xL + xS);
	if (sum == 64'd0) begin
		r.p = {sa & sb, 31'd0};		// Negative only if both are
		return r;
	end
	sgn = bigB ? sb : sa;
	p = 63;
	while (!sum[p]) p--;
	e = eL + p - 55;						// Hidden bit of xL sits at 55
	q = sum >> (p - 23);
	rem = sum & ((64'd1 << (p - 23)) - 64'd1);
	half = 64'd1 << (p - 24);
	lost = (rem != 64'd0);
	if (e < 1) begin
		r.p = {sgn, 31'd0};			// Tiny, flush
		r.flags.underflow = lost;
		r.flags.inexact = lost;
		return r;
	end
	if ((rem > half) || ((rem == half) && q[0])) q = q + 64'd1;
	if (q[24]) begin
		q = q >> 1;					// Mantissa wrapped
		e = e + 1;
	end
	if (e >= `FP_EXP_MAX) begin
		r.p = {sgn, 8'hFF, 23'd0};
		r.flags.overflow = 1'b1;
		r.flags.inexact = 1'b1;
		return r;
	end
	r.p = {sgn, e[7:0], q[22:0]};
	r.flags.inexact = lost;
	return r;
endfunction

`endif

//--- sim/fpAddSubTb.sv
`timescale 1ns/10ps
`include "fpAddCfg.svh"

module fpAddSubTb;
	import fpAddPkg::*;

	`include "fpAddRefModel.svh"

	localparam int nRandom = 400;
	localparam int nCancel = 20;		// Three ops each
	localparam int nSpecial = 12;
	localparam int nRangeFixed = 6;
	localparam int nRangeRand = 20;		// Per end of the range
	localparam int nStress = 300;
	localparam int totalReqs = nRandom + 3 * nCancel + 8 + nSpecial + nRangeFixed +
		2 * nRangeRand + nStress;
	localparam int timeoutCycles = 10 * (totalReqs + `FP_STAGES);

	logic clk;
	logic rst;
	logic reqValid;
	logic reqReady;
	addReqT req;
	logic resValid;
	logic resReady;
	resultT res;

	int seed;
	int checks;
	int errors;
	int chk0;				// Counts at start of test
	int err0;
	int edgeCount;
	logic stressMode;		// Random resReady and gaps
	logic checkLatency;
	resultT expQ[$];
	addReqT reqQ[$];
	int accQ[$];			// Edge of each accepted request
	resultT want;
	addReqT seen;
	int accEdge;
	fpWordT x;

	fpAddSub u_dut (
		.clk(clk),
		.rst(rst),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.req(req),
		.resValid(resValid),
		.resReady(resReady),
		.res(res)
	);

	always #50 clk = ~clk;

	task automatic checkValue(input logic [63:0] got, input logic [63:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic pickResReady();
		logic [31:0] rnd;
		rnd = $random(seed);
		resReady = stressMode ? rnd[0] : 1'b1;
	endtask

	// Hold request until taken, inputs change only on falling edges
	task automatic sendOp(input fpWordT a, input fpWordT b, input logic sub);
		logic [31:0] rnd;
		@(negedge clk);
		rnd = $random(seed);
		if (stressMode && rnd[0]) begin
			reqValid = 1'b0;	// Idle gap
			pickResReady();
			@(negedge clk);
		end
		reqValid = 1'b1;
		req.a = a;
		req.b = b;
		req.sub = sub;
		pickResReady();
		#1;
		while (!reqReady) begin
			@(negedge clk);
			pickResReady();
			#1;
		end
		@(posedge clk);
	endtask

	task automatic sendRandomOp(input int lo, input int span);
		logic [31:0] ra;
		logic [31:0] rb;
		logic [31:0] rc;
		int ea;
		int eb;
		ra = $random(seed);
		rb = $random(seed);
		rc = $random(seed);
		ea = lo + int'(rc[15:0]) % span;
		if (rc[16]) eb = ea + int'(rc[19:17]) - 3;		// Close exponents, cancellation and ties
		else eb = lo + int'(rc[30:20]) % span;
		if (eb < lo) eb = lo;
		if (eb > lo + span - 1) eb = lo + span - 1;
		if (rc[3:0] == 4'd0) ra[22:0] = '1;			// Provokes mantissa carry
		sendOp({ra[31], ea[7:0], ra[22:0]}, {rb[31], eb[7:0], rb[22:0]}, rc[31]);
	endtask

	task automatic drainPipe();
		@(negedge clk);
		reqValid = 1'b0;
		pickResReady();
		while (expQ.size() != 0) begin
			@(negedge clk);
			pickResReady();
		end
	endtask

	task automatic finishTest(input string name);
		$display("Test %s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
		chk0 = checks;
		err0 = errors;
	endtask

	// Scoreboard and cycle limit
	always @(posedge clk) begin
		edgeCount = edgeCount + 1;
		if (edgeCount > timeoutCycles) begin
			$display("Timeout: results still missing after %0d cycles", timeoutCycles);
			$display("Done: errors found");
			$finish;
		end else if (!rst) begin
			if (resValid && resReady) begin
				if (expQ.size() == 0) begin
					errors++;
					$display("Unexpected result %h at %0t with no request outstanding", res.p,
						$time);
				end else begin
					want = expQ.pop_front();
					seen = reqQ.pop_front();
					accEdge = accQ.pop_front();
					checkValue(64'(res), 64'(want), $sformatf("a=%h b=%h sub=%0d", seen.a,
						seen.b, seen.sub));
					if (checkLatency) begin
						checkValue(64'(edgeCount - accEdge), 64'(`FP_STAGES), "latency");
					end
				end
			end
			if (reqValid && reqReady) begin
				expQ.push_back(refAddSub(req.a, req.b, req.sub));
				reqQ.push_back(req);
				accQ.push_back(edgeCount);
			end
		end
	end

	initial begin
		seed = 56921;
		clk = 1'b0;
		rst = 1'b1;
		reqValid = 1'b0;
		req = '0;
		resReady = 1'b1;
		stressMode = 1'b0;
		checkLatency = 1'b0;
		checks = 0;
		errors = 0;
		chk0 = 0;
		err0 = 0;
		edgeCount = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		#1;
		checkValue(64'(resValid), 64'd0, "resValid after reset");
		checkValue(64'(reqReady), 64'd1, "reqReady after reset");
		finishTest("reset state");

		checkLatency = 1'b1;
		for (int i = 0; i < nRandom; i++) sendRandomOp(1, 254);
		drainPipe();
		finishTest("random normal operands");

		for (int i = 0; i < nCancel; i++) begin
			x = $random(seed);
			if (x[30:23] == 8'd0 || x[30:23] == 8'hFF) x[30:23] = 8'h7F;
			sendOp(x, x, 1'b1);								// x - x
			sendOp({~x[31], x[30:0]}, {~x[31], x[30:0]}, 1'b1);	// Negated pair
			sendOp(x, {~x[31], x[30:0]}, 1'b0);					// x + -x
		end
		for (int s = 0; s < 8; s++) sendOp({s[2], 31'd0}, {s[1], 31'd0}, s[0]);	// Signed zeros
		drainPipe();
		finishTest("cancellation and zero sign");

		sendOp(32'h7FC00000, 32'h3F800000, 1'b0);	// Quiet NaN
		sendOp(32'h3F800000, 32'h7F800001, 1'b1);	// Signaling NaN
		sendOp(32'hFFFFFFFF, 32'h7F800000, 1'b0);
		sendOp(32'h7F800000, 32'h7F800000, 1'b1);	// Inf - inf
		sendOp(32'h7F800000, 32'hFF800000, 1'b0);
		sendOp(32'h7F800000, 32'hFF800000, 1'b1);
		sendOp(32'hFF800000, 32'h40A00000, 1'b0);	// -inf + 5
		sendOp(32'h40A00000, 32'h7F800000, 1'b1);
		sendOp(32'h00000001, 32'h807FFFFF, 1'b0);	// Both subnormal
		sendOp(32'h003FFFFF, 32'h3FC00000, 1'b0);
		sendOp(32'h80400000, 32'h00000000, 1'b1);
		sendOp(32'h3F800000, 32'h00000010, 1'b1);
		drainPipe();
		finishTest("special values");

		sendOp(32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0);	// Max + max
		sendOp(32'h7F7FFFFF, 32'h73000000, 1'b0);	// Half ulp tie at max
		sendOp(32'hFF7FFFFF, 32'h7F7FFFFF, 1'b1);
		sendOp(32'h00800000, 32'h00800001, 1'b1);	// One ulp below zero
		sendOp(32'h00C00000, 32'h80800000, 1'b0);
		sendOp(32'h01000000, 32'h00800001, 1'b1);	// Just under min normal
		for (int i = 0; i < nRangeRand; i++) sendRandomOp(251, 4);
		for (int i = 0; i < nRangeRand; i++) sendRandomOp(1, 4);
		drainPipe();
		finishTest("range limits");

		checkLatency = 1'b0;
		stressMode = 1'b1;
		for (int i = 0; i < nStress; i++) sendRandomOp(1, 254);
		drainPipe();
		stressMode = 1'b0;
		finishTest("back-pressure");

		$display("Totals: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- verilog/fpAddAlign.sv
`timescale 1ns/10ps
`include "fpAddCfg.svh"

module fpAddAlign (
	input logic clk,
	input logic rst,
	input logic advance,
	input logic inValid,
	input fpAddPkg::alignReqT in,
	output logic outValid,
	output fpAddPkg::execReqT out
);
	import fpAddPkg::*;

	// Room below the significand for the largest shift
	localparam int extW = `FP_SIG_W + (1 << `FP_SHIFT_W);

	logic [extW-1:0] shifted;
	execReqT nxt;

	assign shifted = {in.sigS, {(extW - `FP_SIG_W){1'b0}}} >> in.shamt;

	always_comb begin
		nxt.expL = in.expL;
		nxt.sigL = in.sigL;
		if (in.shiftOut) begin
			// Everything falls past the round bit
			nxt.sigS = '0;
			nxt.g = 1'b0;
			nxt.r = 1'b0;
			nxt.s = |in.sigS;
		end else begin
			nxt.sigS = shifted[extW-1 -: `FP_SIG_W];
			nxt.g = shifted[extW-`FP_SIG_W-1];			// First bit out
			nxt.r = shifted[extW-`FP_SIG_W-2];			// Second bit out
			nxt.s = |shifted[extW-`FP_SIG_W-3:0];		// OR of the rest
		end
		nxt.effSub = in.effSub;
		nxt.maxAB = in.maxAB;
		nxt.sa = in.sa;
		nxt.sb = in.sb;
		nxt.op = in.op;
		nxt.exc = in.exc;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (advance) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			out <= nxt;
		end
	end

endmodule

//--- verilog/fpAddCfg.svh
`ifndef FP_ADD_CFG_SVH
`define FP_ADD_CFG_SVH

// Single precision field layout
`define FP_EXP_W 8		// Biased exponent field
`define FP_MAN_W 23		// Stored mantissa, hidden bit excluded
`define FP_BIAS 127		// Exponent bias

// Derived widths
`define FP_SIG_W (`FP_MAN_W + 1)					// Significand with hidden bit
`define FP_WORD_W (1 + `FP_EXP_W + `FP_MAN_W)		// Whole word
`define FP_SHIFT_W 5								// Alignment shift, 0..31

// All-ones exponent marks Inf and NaN
`define FP_EXP_MAX (2 * `FP_BIAS + 1)

// Quiet NaN returned for invalid operations
`define FP_QNAN 32'h7FC00000

// Register stages between request and result
`define FP_STAGES 4

`endif

//--- verilog/fpAddExecute.sv
`timescale 1ns/10ps
`include "fpAddCfg.svh"

module fpAddExecute (
	input logic clk,
	input logic rst,
	input logic advance,
	input logic inValid,
	input fpAddPkg::execReqT in,
	output logic outValid,
	output fpAddPkg::normT out
);
	import fpAddPkg::*;

	// Carry, significand, then guard, round and sticky
	localparam int sumW = `FP_SIG_W + 4;

	logic [sumW-1:0] opL;
	logic [sumW-1:0] opS;
	logic [sumW-1:0] sum;
	logic [sumW-2:0] shl;		// Left-normalized, carry bit dropped
	shiftT lz;					// Leading zeros below the carry
	normT nxt;

	assign opL = {1'b0, in.sigL, 3'b000};
	assign opS = {1'b0, in.sigS, in.g, in.r, in.s};
	// Larger operand first, so no negative result
	assign sum = in.effSub ? (opL - opS) : (opL + opS);

	// Leading-zero count, highest set bit wins
	always_comb begin
		lz = shiftT'(sumW - 1);
		for (int i = 0; i < sumW - 1; i++) begin
			if (sum[i]) begin
				lz = shiftT'(sumW - 2 - i);
			end
		end
	end

	assign shl = sum[sumW-2:0] << lz;

	always_comb begin
		nxt.zeroSum = (sum == '0);
		if (sum[sumW-1]) begin
			// Carry out, one step right
			nxt.normE = in.expL + 1'b1;
			nxt.normM = sum[sumW-2 -: `FP_MAN_W];
			nxt.g = sum[3];
			nxt.r = sum[2];
			nxt.s = sum[1] | sum[0];
			nxt.negE = 1'b0;
		end else begin
			nxt.normE = in.expL - lz;
			nxt.normM = shl[sumW-3 -: `FP_MAN_W];		// Hidden bit at top dropped
			nxt.g = shl[2];
			nxt.r = shl[1];
			nxt.s = shl[0];
			nxt.negE = ~nxt.zeroSum & (lz >= in.expL);	// Would land at exponent 0 or less
		end
		nxt.sa = in.sa;
		nxt.sb = in.sb;
		nxt.op = in.op;
		nxt.maxAB = in.maxAB;
		nxt.exc = in.exc;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (advance) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			out <= nxt;
		end
	end

endmodule

//--- verilog/fpAddPkg.sv
`include "fpAddCfg.svh"

package fpAddPkg;

	typedef logic [`FP_WORD_W-1:0] fpWordT;		// Raw IEEE word
	typedef logic [`FP_EXP_W:0] expT;			// Exponent, top bit catches overflow
	typedef logic [`FP_SIG_W-1:0] sigT;			// Significand incl. hidden bit
	typedef logic [`FP_MAN_W-1:0] manT;			// Stored mantissa
	typedef logic [`FP_SHIFT_W-1:0] shiftT;		// Alignment distance

	typedef struct packed {
		fpWordT a;
		fpWordT b;
		logic sub;		// Set for a - b
	} addReqT;

	// Input exception classes
	typedef struct packed {
		logic nanIn;		// Either operand NaN
		logic infSubInf;	// Opposite infinities cancel
		logic infA;
		logic infB;
		logic spare;		// Always zero
	} excT;

	// Prealign to align
	typedef struct packed {
		expT expL;			// Exponent of larger magnitude
		sigT sigL;
		sigT sigS;			// Still unshifted here
		shiftT shamt;
		logic shiftOut;		// Difference beyond shifter range
		logic effSub;		// Magnitudes get subtracted
		logic maxAB;		// B is larger, its sign wins
		logic sa;
		logic sb;
		logic op;
		excT exc;
	} alignReqT;

	// Align to execute
	typedef struct packed {
		expT expL;
		sigT sigL;
		sigT sigS;			// Aligned to sigL
		logic g;
		logic r;
		logic s;
		logic effSub;
		logic maxAB;
		logic sa;
		logic sb;
		logic op;
		excT exc;
	} execReqT;

	// Execute to round
	typedef struct packed {
		logic zeroSum;		// Exact zero
		expT normE;
		manT normM;
		logic g;
		logic r;
		logic s;
		logic negE;			// Exponent below 1, flush
		logic sa;
		logic sb;
		logic op;
		logic maxAB;
		excT exc;
	} normT;

	typedef struct packed {
		logic overflow;
		logic underflow;
		logic divideByZero;	// Never set by add/sub
		logic invalid;
		logic inexact;
	} flagsT;

	typedef struct packed {
		fpWordT p;
		flagsT flags;
	} resultT;

endpackage

//--- verilog/fpAddPrealign.sv
`timescale 1ns/10ps
`include "fpAddCfg.svh"

module fpAddPrealign (
	input logic clk,
	input logic rst,
	input logic advance,
	input logic inValid,
	input fpAddPkg::addReqT in,
	output logic outValid,
	output fpAddPkg::alignReqT out
);
	import fpAddPkg::*;

	logic [`FP_EXP_W-1:0] ea;
	logic [`FP_EXP_W-1:0] eb;
	logic [`FP_EXP_W-1:0] diff;		// Large exponent minus small one
	sigT sigA;
	sigT sigB;
	logic bigB;						// |B| > |A|
	logic nanA;
	logic nanB;
	logic infA;
	logic infB;
	alignReqT nxt;

	// Field split
	assign ea = in.a[`FP_WORD_W-2 -: `FP_EXP_W];
	assign eb = in.b[`FP_WORD_W-2 -: `FP_EXP_W];

	// Zero and subnormal operands both read as zero
	assign sigA = (ea != '0) ? {1'b1, in.a[`FP_MAN_W-1:0]} : '0;
	assign sigB = (eb != '0) ? {1'b1, in.b[`FP_MAN_W-1:0]} : '0;

	assign bigB = {eb, sigB} > {ea, sigA};	// Equal magnitudes keep A first
	assign diff = bigB ? (eb - ea) : (ea - eb);

	// Special operand classes
	assign nanA = (ea == `FP_EXP_W'(`FP_EXP_MAX)) & (in.a[`FP_MAN_W-1:0] != '0);
	assign nanB = (eb == `FP_EXP_W'(`FP_EXP_MAX)) & (in.b[`FP_MAN_W-1:0] != '0);
	assign infA = (ea == `FP_EXP_W'(`FP_EXP_MAX)) & (in.a[`FP_MAN_W-1:0] == '0);
	assign infB = (eb == `FP_EXP_W'(`FP_EXP_MAX)) & (in.b[`FP_MAN_W-1:0] == '0);

	always_comb begin
		nxt.expL = bigB ? {1'b0, eb} : {1'b0, ea};
		nxt.sigL = bigB ? sigB : sigA;
		nxt.sigS = bigB ? sigA : sigB;
		nxt.shamt = diff[`FP_SHIFT_W-1:0];
		nxt.shiftOut = |diff[`FP_EXP_W-1:`FP_SHIFT_W];	// Gap of 32 or more
		nxt.sa = in.a[`FP_WORD_W-1];
		nxt.sb = in.b[`FP_WORD_W-1];
		nxt.op = in.sub;
		nxt.effSub = nxt.sa ^ nxt.sb ^ in.sub;		// Signs differ after op
		nxt.maxAB = bigB;
		nxt.exc.nanIn = nanA | nanB;
		nxt.exc.infSubInf = infA & infB & nxt.effSub;
		nxt.exc.infA = infA;
		nxt.exc.infB = infB;
		nxt.exc.spare = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (advance) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			out <= nxt;
		end
	end

endmodule

//--- verilog/fpAddRound.sv
`timescale 1ns/10ps
`include "fpAddCfg.svh"

module fpAddRound (
	input logic clk,
	input logic rst,
	input logic advance,
	input logic inValid,
	input fpAddPkg::normT in,
	output logic outValid,
	output fpAddPkg::resultT out
);
	import fpAddPkg::*;

	logic roundUp;
	logic [`FP_MAN_W:0] roundUpM;		// Extra bit for mantissa carry
	manT roundM;
	expT roundE;
	logic eof;							// Exponent overflow
	logic fSgn;
	logic infSgn;						// Sign of the infinite operand
	logic invalid;
	logic infIn;
	resultT nxt;

	// Nearest, ties to even
	assign roundUp = in.g & (in.r | in.s | in.normM[0]);
	assign roundUpM = in.normM + 1'b1;
	assign roundM = roundUp ? roundUpM[`FP_MAN_W-1:0] : in.normM;
	assign roundE = in.zeroSum ? '0 : (in.normE + (roundUp & roundUpM[`FP_MAN_W]));
	assign eof = ~in.negE & (roundE >= expT'(`FP_EXP_MAX));

	// Exact zero is negative only if both effective signs are
	assign fSgn = in.zeroSum ? (in.sa & (in.sb ^ in.op)) :
		(in.maxAB ? (in.sb ^ in.op) : in.sa);
	assign infSgn = in.exc.infA ? in.sa : (in.sb ^ in.op);

	assign invalid = in.exc.nanIn | in.exc.infSubInf;
	assign infIn = (in.exc.infA | in.exc.infB) & ~invalid;

	always_comb begin
		if (invalid) begin
			nxt.p = `FP_QNAN;
		end else if (infIn | eof) begin
			nxt.p = {infIn ? infSgn : fSgn, {`FP_EXP_W{1'b1}}, manT'(0)};
		end else if (in.negE) begin
			nxt.p = {fSgn, {(`FP_WORD_W - 1){1'b0}}};	// Flushed, signed zero
		end else begin
			nxt.p = {fSgn, roundE[`FP_EXP_W-1:0], roundM};
		end
		nxt.flags.overflow = infIn | (eof & ~invalid);
		nxt.flags.underflow = in.negE & (in.g | in.r | in.s);
		nxt.flags.divideByZero = 1'b0;
		nxt.flags.invalid = invalid;
		// Lost bits only count for finite results
		nxt.flags.inexact = ((in.g | in.r | in.s) & ~invalid & ~infIn) |
			nxt.flags.overflow | nxt.flags.underflow;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (advance) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			out <= nxt;
		end
	end

endmodule

//--- verilog/fpAddSub.sv
`timescale 1ns/10ps
`include "fpAddCfg.svh"

module fpAddSub (
	input logic clk,
	input logic rst,
	input logic reqValid,
	output logic reqReady,
	input fpAddPkg::addReqT req,
	output logic resValid,
	input logic resReady,
	output fpAddPkg::resultT res
);
	import fpAddPkg::*;

	logic advance;						// Whole pipe shifts one stage
	logic [`FP_STAGES-1:0] stageValid;	// Index 0 is prealign
	alignReqT alignW;
	execReqT execW;
	normT normW;

	// Move unless the last stage is full and stalled
	assign advance = ~stageValid[`FP_STAGES-1] | resReady;
	assign reqReady = advance;
	assign resValid = stageValid[`FP_STAGES-1];	// Result handshake 4 edges after request

	fpAddPrealign uPrealign (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.inValid(reqValid),
		.in(req),
		.outValid(stageValid[0]),
		.out(alignW)
	);

	fpAddAlign uAlign (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.inValid(stageValid[0]),
		.in(alignW),
		.outValid(stageValid[1]),
		.out(execW)
	);

	fpAddExecute uExecute (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.inValid(stageValid[1]),
		.in(execW),
		.outValid(stageValid[2]),
		.out(normW)
	);

	// Last stage output is the result port
	fpAddRound uRound (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.inValid(stageValid[2]),
		.in(normW),
		.outValid(stageValid[3]),
		.out(res)
	);

endmodule

//--- vlog.f
+incdir+verilog
+incdir+sim
verilog/fpAddPkg.sv
verilog/fpAddPrealign.sv
verilog/fpAddAlign.sv
verilog/fpAddExecute.sv
verilog/fpAddRound.sv
verilog/fpAddSub.sv
sim/fpAddSubTb.sv
